//--- rtl/wisc_params.svh
`ifndef WISC_PARAMS_SVH
`define WISC_PARAMS_SVH

// Operand and result width of the datapath
`define DATA_WIDTH 16

// Major opcode field width
`define OPCODE_WIDTH 5

// Shift amount width, enough for 0 to 15
`define SHAMT_WIDTH 4

`endif

//--- rtl/isaPkg.sv
`default_nettype none

`include "wisc_params.svh"

package isaPkg;

    // Supported major opcodes
    typedef enum logic [`OPCODE_WIDTH-1:0] {
        J      = 5'b00100,
        JR     = 5'b00101,
        ADDI   = 5'b01000,
        SUBI   = 5'b01001,
        XORI   = 5'b01010,
        ANDNI  = 5'b01011,
        BEQZ   = 5'b01100,
        BNEZ   = 5'b01101,
        BLTZ   = 5'b01110,
        BGEZ   = 5'b01111,
        SLBI   = 5'b10010,
        ROLI   = 5'b10100,
        SLLI   = 5'b10101,
        RORI   = 5'b10110,
        SRLI   = 5'b10111,
        LBI    = 5'b11000,
        BTR    = 5'b11001,
        RSHIFT = 5'b11010,
        RALU   = 5'b11011,
        SEQ    = 5'b11100,
        SLT    = 5'b11101,
        SLE    = 5'b11110,
        SCO    = 5'b11111
    } opcodeT;

    // Function field, meaning depends on the register group
    typedef logic [1:0] funcT;

    // RALU group
    localparam funcT FN_ADD  = 2'b00;
    localparam funcT FN_SUB  = 2'b01;
    localparam funcT FN_XOR  = 2'b10;
    localparam funcT FN_ANDN = 2'b11;

    // RSHIFT group
    localparam funcT FN_ROL = 2'b00;
    localparam funcT FN_SLL = 2'b01;
    localparam funcT FN_ROR = 2'b10;
    localparam funcT FN_SRL = 2'b11;

    // Three-register format
    typedef struct packed {
        opcodeT     opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        funcT       func;
    } rTypeT;

    // Two registers and a 5-bit immediate
    typedef struct packed {
        opcodeT     opcode;
        logic [2:0] rs;
        logic [2:0] rd;
        logic [4:0] imm5;
    } i1TypeT;

    // One register and an 8-bit immediate
    typedef struct packed {
        opcodeT     opcode;
        logic [2:0] rs;
        logic [7:0] imm8;
    } i2TypeT;

    // Jump displacement format
    typedef struct packed {
        opcodeT      opcode;
        logic [10:0] disp11;
    } jTypeT;

    // One instruction word, read in the format its opcode implies
    typedef union packed {
        rTypeT  rType;
        i1TypeT i1Type;
        i2TypeT i2Type;
        jTypeT  jType;
    } instrU;

endpackage

`default_nettype wire

//--- rtl/aluPkg.sv
`default_nettype none

`include "wisc_params.svh"

package aluPkg;

    // ALU operation codes
    // Low two bits of the shift group go straight to the shifter
    typedef enum logic [3:0] {
        OP_ROL   = 4'b0000,
        OP_SLL   = 4'b0001,
        OP_SRA   = 4'b0010,
        OP_SRL   = 4'b0011,
        OP_ADD   = 4'b0100,
        OP_AND   = 4'b0101,
        OP_OR    = 4'b0110,
        OP_XOR   = 4'b0111,
        OP_BTR   = 4'b1000,
        OP_SEQ   = 4'b1001,
        OP_SLT   = 4'b1010,
        OP_SLE   = 4'b1011,
        OP_SCO   = 4'b1100,
        OP_PASSB = 4'b1101,
        OP_SLBI  = 4'b1110,
        OP_PASSA = 4'b1111
    } aluOpT;

    // Controls from the decoder to the ALU
    typedef struct packed {
        aluOpT op;
        logic  invA;
        logic  invB;
        logic  cIn;
        logic  sign;
    } aluCtrlT;

    // Branch and jump kinds
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQZ  = 3'd1,
        BR_NEZ  = 3'd2,
        BR_LTZ  = 3'd3,
        BR_GEZ  = 3'd4,
        BR_JREL = 3'd5,
        BR_JREG = 3'd6
    } branchKindT;

    // Registered output of the execute stage
    typedef struct packed {
        logic [`DATA_WIDTH-1:0] aluOut;
        logic                   zero;
        logic                   ofl;
        logic                   writeEn;
        logic                   branchTaken;
        logic [`DATA_WIDTH-1:0] branchTarget;
    } exResultT;

endpackage

`default_nettype wire

//--- rtl/shifter.sv
`timescale 1ns/10ps
`default_nettype none

`include "wisc_params.svh"

module shifter (
    input  wire logic [`DATA_WIDTH-1:0]  In,
    input  wire logic [`SHAMT_WIDTH-1:0] ShAmt,
    input  wire logic [1:0]              Oper,
    output logic      [`DATA_WIDTH-1:0]  Out
);

    localparam int W = `DATA_WIDTH;
    localparam int S = `SHAMT_WIDTH;

    // Stage i moves by 2**i when ShAmt[i] is set
    logic [W-1:0] stg [0:S];

    assign stg[0] = In;

    for (genvar i = 0; i < S; i++) begin : gStage
        localparam int N = 1 << i;
        logic [W-1:0] moved;

        always_comb begin
            case (Oper)
                // Rotate left
                2'b00:   moved = {stg[i][W-N-1:0], stg[i][W-1:W-N]};
                // Shift left, zero fill
                2'b01:   moved = {stg[i][W-N-1:0], {N{1'b0}}};
                // Shift right, sign fill
                2'b10:   moved = {{N{stg[i][W-1]}}, stg[i][W-1:N]};
                // Shift right, zero fill
                default: moved = {{N{1'b0}}, stg[i][W-1:N]};
            endcase
        end

        assign stg[i+1] = ShAmt[i] ? moved : stg[i];
    end

    assign Out = stg[S];

endmodule

`default_nettype wire

//--- rtl/claAdder.sv
`timescale 1ns/10ps
`default_nettype none

`include "wisc_params.svh"

module claAdder (
    input  wire logic [`DATA_WIDTH-1:0] a,
    input  wire logic [`DATA_WIDTH-1:0] b,
    input  wire logic                   cIn,
    output logic      [`DATA_WIDTH-1:0] sum,
    output logic                        cOut
);

    localparam int W  = `DATA_WIDTH;
    localparam int NG = W / 4;

    // Bit generate and propagate
    logic [W-1:0]  g;
    logic [W-1:0]  p;
    logic [NG-1:0] grpG;
    logic [NG-1:0] grpP;
    // Carry into each group, plus the final carry
    logic [NG:0]   grpC;
    // Carry into each bit
    logic [W-1:0]  cBit;

    assign g = a & b;
    assign p = a ^ b;

    // First level, inside each 4-bit group
    for (genvar k = 0; k < NG; k++) begin : gGroup
        localparam int B = 4 * k;

        assign grpG[k] = g[B+3] | (p[B+3] & g[B+2]) | (p[B+3] & p[B+2] & g[B+1])
                       | (p[B+3] & p[B+2] & p[B+1] & g[B]);
        assign grpP[k] = &p[B+3:B];

        assign cBit[B]   = grpC[k];
        assign cBit[B+1] = g[B] | (p[B] & grpC[k]);
        assign cBit[B+2] = g[B+1] | (p[B+1] & g[B]) | (p[B+1] & p[B] & grpC[k]);
        assign cBit[B+3] = g[B+2] | (p[B+2] & g[B+1]) | (p[B+2] & p[B+1] & g[B])
                         | (p[B+2] & p[B+1] & p[B] & grpC[k]);
    end

    // Second level, across the four groups
    assign grpC[0] = cIn;
    assign grpC[1] = grpG[0] | (grpP[0] & cIn);
    assign grpC[2] = grpG[1] | (grpP[1] & grpG[0]) | (grpP[1] & grpP[0] & cIn);
    assign grpC[3] = grpG[2] | (grpP[2] & grpG[1]) | (grpP[2] & grpP[1] & grpG[0])
                   | (grpP[2] & grpP[1] & grpP[0] & cIn);
    assign grpC[4] = grpG[3] | (grpP[3] & grpG[2]) | (grpP[3] & grpP[2] & grpG[1])
                   | (grpP[3] & grpP[2] & grpP[1] & grpG[0])
                   | (grpP[3] & grpP[2] & grpP[1] & grpP[0] & cIn);

    assign sum  = p ^ cBit;
    assign cOut = grpC[NG];

endmodule

`default_nettype wire

//--- rtl/aluBranchJump.sv
`timescale 1ns/10ps
`default_nettype none

`include "wisc_params.svh"

module aluBranchJump (
    input  wire logic [`DATA_WIDTH-1:0] InA,
    input  wire logic [`DATA_WIDTH-1:0] InB,
    input  wire aluPkg::aluCtrlT        aluCtrl,
    output logic      [`DATA_WIDTH-1:0] aluOut,
    output logic                        zero,
    output logic                        ofl
);

    localparam int W = `DATA_WIDTH;

    // Operands after optional inversion
    logic [W-1:0] opA;
    logic [W-1:0] opB;
    logic [W-1:0] shiftOut;
    logic [W-1:0] sum;
    logic         cOut;
    logic [W-1:0] revA;
    logic         signedOfl;
    logic         seqBit;
    logic         sltBit;
    logic         usesAdder;

    assign opA = aluCtrl.invA ? ~InA : InA;
    assign opB = aluCtrl.invB ? ~InB : InB;

    // Amount comes from the low bits of B
    shifter u_shifter (
        .In    (opA),
        .ShAmt (opB[`SHAMT_WIDTH-1:0]),
        .Oper  (aluCtrl.op[1:0]),
        .Out   (shiftOut)
    );

    claAdder u_claAdder (
        .a    (opA),
        .b    (opB),
        .cIn  (aluCtrl.cIn),
        .sum  (sum),
        .cOut (cOut)
    );

    // Bit reversal of A
    always_comb begin
        for (int i = 0; i < W; i++) begin
            revA[i] = opA[W-1-i];
        end
    end

    // Like-signed operands with a sum of the other sign
    assign signedOfl = (opA[W-1] == opB[W-1]) & (sum[W-1] != opA[W-1]);

    // Comparisons see rs minus rt
    assign seqBit = ~|sum;
    // Sum sign is flipped when the difference overflowed
    assign sltBit = sum[W-1] ^ signedOfl;

    // Overflow only means something where the adder drives the result
    assign usesAdder = aluCtrl.op inside {aluPkg::OP_ADD, aluPkg::OP_SEQ, aluPkg::OP_SLT,
                                          aluPkg::OP_SLE, aluPkg::OP_SCO};
    assign ofl = usesAdder & (aluCtrl.sign ? signedOfl : cOut);

    always_comb begin
        case (aluCtrl.op)
            aluPkg::OP_ROL,
            aluPkg::OP_SLL,
            aluPkg::OP_SRA,
            aluPkg::OP_SRL:   aluOut = shiftOut;
            aluPkg::OP_ADD:   aluOut = sum;
            aluPkg::OP_AND:   aluOut = opA & opB;
            aluPkg::OP_OR:    aluOut = opA | opB;
            aluPkg::OP_XOR:   aluOut = opA ^ opB;
            aluPkg::OP_BTR:   aluOut = revA;
            aluPkg::OP_SEQ:   aluOut = {{(W-1){1'b0}}, seqBit};
            aluPkg::OP_SLT:   aluOut = {{(W-1){1'b0}}, sltBit};
            aluPkg::OP_SLE:   aluOut = {{(W-1){1'b0}}, seqBit | sltBit};
            aluPkg::OP_SCO:   aluOut = {{(W-1){1'b0}}, cOut};
            aluPkg::OP_PASSB: aluOut = opB;
            // Old rs moves up a byte, immediate fills the low byte
            aluPkg::OP_SLBI:  aluOut = (opA << 8) | opB;
            default:          aluOut = opA;
        endcase
    end

    assign zero = ~|aluOut;

endmodule

`default_nettype wire

//--- rtl/instrDecode.sv
`timescale 1ns/10ps
`default_nettype none

`include "wisc_params.svh"

module instrDecode (
    input  wire isaPkg::instrU          instr,
    input  wire logic [`DATA_WIDTH-1:0] rtData,
    output aluPkg::aluCtrlT             aluCtrl,
    output logic      [`DATA_WIDTH-1:0] opB,
    output aluPkg::branchKindT          branchKind,
    output logic      [`DATA_WIDTH-1:0] imm,
    output logic                        writeEn
);

    localparam int W = `DATA_WIDTH;
    localparam int S = `SHAMT_WIDTH;

    logic [W-1:0] imm5Sext;
    logic [W-1:0] imm5Zext;
    logic [W-1:0] imm8Sext;
    logic [W-1:0] imm8Zext;
    logic [W-1:0] disp11Sext;
    // Rotate right becomes rotate left by the negated amount
    logic [S-1:0] negImmAmt;
    logic [S-1:0] negRegAmt;

    assign imm5Sext   = {{(W-5){instr.i1Type.imm5[4]}}, instr.i1Type.imm5};
    assign imm5Zext   = {{(W-5){1'b0}}, instr.i1Type.imm5};
    assign imm8Sext   = {{(W-8){instr.i2Type.imm8[7]}}, instr.i2Type.imm8};
    assign imm8Zext   = {{(W-8){1'b0}}, instr.i2Type.imm8};
    assign disp11Sext = {{(W-11){instr.jType.disp11[10]}}, instr.jType.disp11};
    assign negImmAmt  = S'(0) - instr.i1Type.imm5[S-1:0];
    assign negRegAmt  = S'(0) - rtData[S-1:0];

    always_comb begin
        // Defaults: pass rs, no write, no branch
        aluCtrl    = '{op: aluPkg::OP_PASSA, invA: 1'b0, invB: 1'b0, cIn: 1'b0, sign: 1'b0};
        opB        = rtData;
        branchKind = aluPkg::BR_NONE;
        imm        = '0;
        writeEn    = 1'b0;

        case (instr.rType.opcode)
            isaPkg::ADDI: begin
                aluCtrl.op   = aluPkg::OP_ADD;
                aluCtrl.sign = 1'b1;
                opB          = imm5Sext;
                writeEn      = 1'b1;
            end
            // Immediate minus rs
            isaPkg::SUBI: begin
                aluCtrl = '{op: aluPkg::OP_ADD, invA: 1'b1, invB: 1'b0, cIn: 1'b1, sign: 1'b1};
                opB     = imm5Sext;
                writeEn = 1'b1;
            end
            isaPkg::XORI: begin
                aluCtrl.op = aluPkg::OP_XOR;
                opB        = imm5Zext;
                writeEn    = 1'b1;
            end
            isaPkg::ANDNI: begin
                aluCtrl.op   = aluPkg::OP_AND;
                aluCtrl.invB = 1'b1;
                opB          = imm5Zext;
                writeEn      = 1'b1;
            end
            isaPkg::ROLI, isaPkg::SLLI, isaPkg::SRLI: begin
                aluCtrl.op = aluPkg::aluOpT'({2'b00, instr.rType.opcode[1:0]});
                opB        = imm5Zext;
                writeEn    = 1'b1;
            end
            isaPkg::RORI: begin
                aluCtrl.op = aluPkg::OP_ROL;
                opB        = {{(W-S){1'b0}}, negImmAmt};
                writeEn    = 1'b1;
            end
            isaPkg::RALU: begin
                writeEn = 1'b1;
                case (instr.rType.func)
                    isaPkg::FN_ADD: begin
                        aluCtrl.op   = aluPkg::OP_ADD;
                        aluCtrl.sign = 1'b1;
                    end
                    // rt minus rs
                    isaPkg::FN_SUB: aluCtrl = '{op: aluPkg::OP_ADD, invA: 1'b1, invB: 1'b0,
                                                cIn: 1'b1, sign: 1'b1};
                    isaPkg::FN_XOR: aluCtrl.op = aluPkg::OP_XOR;
                    default: begin
                        aluCtrl.op   = aluPkg::OP_AND;
                        aluCtrl.invB = 1'b1;
                    end
                endcase
            end
            isaPkg::RSHIFT: begin
                writeEn = 1'b1;
                if (instr.rType.func == isaPkg::FN_ROR) begin
                    aluCtrl.op = aluPkg::OP_ROL;
                    opB        = {{(W-S){1'b0}}, negRegAmt};
                end else begin
                    // ROL, SLL and SRL codes line up with the ALU shift codes
                    aluCtrl.op = aluPkg::aluOpT'({2'b00, instr.rType.func});
                end
            end
            // Compare as rs minus rt
            isaPkg::SEQ, isaPkg::SLT, isaPkg::SLE: begin
                aluCtrl = '{op: aluPkg::aluOpT'({2'b10, instr.rType.opcode[1:0]} + 4'd1),
                            invA: 1'b0, invB: 1'b1, cIn: 1'b1, sign: 1'b1};
                writeEn = 1'b1;
            end
            isaPkg::SCO: begin
                aluCtrl.op = aluPkg::OP_SCO;
                writeEn    = 1'b1;
            end
            isaPkg::BTR: begin
                aluCtrl.op = aluPkg::OP_BTR;
                writeEn    = 1'b1;
            end
            isaPkg::LBI: begin
                aluCtrl.op = aluPkg::OP_PASSB;
                opB        = imm8Sext;
                writeEn    = 1'b1;
            end
            isaPkg::SLBI: begin
                aluCtrl.op = aluPkg::OP_SLBI;
                opB        = imm8Zext;
                writeEn    = 1'b1;
            end
            // Branches test rs through pass-A
            isaPkg::BEQZ, isaPkg::BNEZ, isaPkg::BLTZ, isaPkg::BGEZ: begin
                branchKind = aluPkg::branchKindT'({1'b0, instr.rType.opcode[1:0]} + 3'd1);
                opB        = imm8Sext;
                imm        = imm8Sext;
            end
            isaPkg::J: begin
                branchKind = aluPkg::BR_JREL;
                imm        = disp11Sext;
            end
            // Target is rs plus offset, formed by the adder
            isaPkg::JR: begin
                aluCtrl.op = aluPkg::OP_ADD;
                opB        = imm8Sext;
                imm        = imm8Sext;
                branchKind = aluPkg::BR_JREG;
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- rtl/branchResolve.sv
`timescale 1ns/10ps
`default_nettype none

`include "wisc_params.svh"

module branchResolve (
    input  wire aluPkg::branchKindT     branchKind,
    input  wire logic [`DATA_WIDTH-1:0] pc,
    input  wire logic [`DATA_WIDTH-1:0] imm,
    input  wire logic                   zero,
    input  wire logic [`DATA_WIDTH-1:0] aluOut,
    output logic                        branchTaken,
    output logic      [`DATA_WIDTH-1:0] branchTarget
);

    localparam int W = `DATA_WIDTH;

    logic [W-1:0] nextPc;
    logic         rsNeg;

    assign nextPc = pc + W'(2);
    // For branches aluOut is rs itself
    assign rsNeg  = aluOut[W-1];

    always_comb begin
        case (branchKind)
            aluPkg::BR_EQZ:  branchTaken = zero;
            aluPkg::BR_NEZ:  branchTaken = ~zero;
            aluPkg::BR_LTZ:  branchTaken = rsNeg;
            aluPkg::BR_GEZ:  branchTaken = ~rsNeg;
            aluPkg::BR_JREL,
            aluPkg::BR_JREG: branchTaken = 1'b1;
            default:         branchTaken = 1'b0;
        endcase
    end

    // Fall-through address unless taken
    always_comb begin
        if (!branchTaken) begin
            branchTarget = nextPc;
        end else if (branchKind == aluPkg::BR_JREG) begin
            branchTarget = aluOut;
        end else begin
            branchTarget = nextPc + imm;
        end
    end

endmodule

`default_nettype wire

//--- rtl/executeStage.sv
`timescale 1ns/10ps
`default_nettype none

`include "wisc_params.svh"

module executeStage (
    input  wire logic                   clk,
    input  wire logic                   rstN,
    input  wire logic                   instrValid,
    input  wire isaPkg::instrU          instr,
    input  wire logic [`DATA_WIDTH-1:0] rsData,
    input  wire logic [`DATA_WIDTH-1:0] rtData,
    input  wire logic [`DATA_WIDTH-1:0] pc,
    output logic                        resultValid,
    output aluPkg::exResultT            result
);

    aluPkg::aluCtrlT        aluCtrl;
    aluPkg::branchKindT     branchKind;
    aluPkg::exResultT       nextResult;
    logic [`DATA_WIDTH-1:0] opB;
    logic [`DATA_WIDTH-1:0] imm;
    logic                   writeEn;
    logic [`DATA_WIDTH-1:0] aluOut;
    logic                   zero;
    logic                   ofl;
    logic                   branchTaken;
    logic [`DATA_WIDTH-1:0] branchTarget;

    instrDecode u_instrDecode (
        .instr      (instr),
        .rtData     (rtData),
        .aluCtrl    (aluCtrl),
        .opB        (opB),
        .branchKind (branchKind),
        .imm        (imm),
        .writeEn    (writeEn)
    );

    // rs is always operand A
    aluBranchJump u_aluBranchJump (
        .InA     (rsData),
        .InB     (opB),
        .aluCtrl (aluCtrl),
        .aluOut  (aluOut),
        .zero    (zero),
        .ofl     (ofl)
    );

    branchResolve u_branchResolve (
        .branchKind   (branchKind),
        .pc           (pc),
        .imm          (imm),
        .zero         (zero),
        .aluOut       (aluOut),
        .branchTaken  (branchTaken),
        .branchTarget (branchTarget)
    );

    assign nextResult = '{aluOut: aluOut, zero: zero, ofl: ofl, writeEn: writeEn,
                          branchTaken: branchTaken, branchTarget: branchTarget};

    // Valid follows the strobe by one cycle
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= instrValid;
        end
    end

    // Result holds between instructions
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            result <= '0;
        end else if (instrValid) begin
            result <= nextResult;
        end
    end

    // Adder path matches a plain add, or operand B minus rs when A is inverted
    assert property (@(posedge clk) disable iff (!rstN)
        instrValid && aluCtrl.op == aluPkg::OP_ADD |->
            aluOut == (aluCtrl.invA ? opB - rsData : rsData + opB + aluCtrl.cIn))
        else $error("adder result disagrees with its operands");

    // Register jump lands on rs plus the offset
    assert property (@(posedge clk) disable iff (!rstN)
        instrValid && branchKind == aluPkg::BR_JREG |-> branchTarget == rsData + imm)
        else $error("jump-register target is not rs plus offset");

endmodule

`default_nettype wire

//--- testbench/tbClock.sv
`timescale 1ns/10ps
`default_nettype none

module tbClock (
    output logic clk,
    output logic rstN
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Reset spans five rising edges, released on a falling edge
    initial begin
        rstN = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstN = 1'b1;
    end

endmodule

`default_nettype wire

//--- testbench/tbExecute.sv
`timescale 1ns/10ps
`default_nettype none

`include "wisc_params.svh"

module tbExecute;

    localparam int    W          = `DATA_WIDTH;
    localparam int    FIELDS     = 10;
    localparam int    TIMEOUT    = 20;
    localparam int    MAX_LINES  = 200;
    localparam string TRACE_FILE = "testbench/exec_trace.txt";

    logic             clk;
    logic             rstN;
    logic             instrValid;
    isaPkg::instrU    instr;
    logic [W-1:0]     rsData;
    logic [W-1:0]     rtData;
    logic [W-1:0]     pc;
    logic             resultValid;
    aluPkg::exResultT result;

    // Columns of the current trace line
    logic [W-1:0] traceFields [0:FIELDS-1];
    int unsigned  lcgState;
    int           errors;
    int           testsRun;
    int           failedTests;
    bit           timedOut;

    tbClock u_tbClock (
        .clk  (clk),
        .rstN (rstN)
    );

    executeStage u_executeStage (
        .clk         (clk),
        .rstN        (rstN),
        .instrValid  (instrValid),
        .instr       (instr),
        .rsData      (rsData),
        .rtData      (rtData),
        .pc          (pc),
        .resultValid (resultValid),
        .result      (result)
    );

    // LCG step, upper half mixes better
    function automatic int unsigned nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState >> 16;
    endfunction

    // Called on a falling edge only
    task automatic driveInstr(input logic [W-1:0] word, input logic [W-1:0] rs,
                              input logic [W-1:0] rt, input logic [W-1:0] addr);
        instr      = word;
        rsData     = rs;
        rtData     = rt;
        pc         = addr;
        instrValid = 1'b1;
    endtask

    // Nothing in flight, so no result may appear
    task automatic checkIdle(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            @(negedge clk);
            if (resultValid !== 1'b0) begin
                $display("ERR %0t: resultValid high with no instruction in flight", $time);
                errors++;
            end
        end
    endtask

    // Bounded wait for the result strobe
    task automatic waitResult(output bit seen, output int cycles);
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < TIMEOUT) begin
            @(negedge clk);
            cycles++;
            seen = (resultValid === 1'b1);
        end
    endtask

    task automatic checkData(input aluPkg::exResultT got, input aluPkg::exResultT exp);
        if (got.aluOut !== exp.aluOut) begin
            $display("ERR %0t: aluOut %h, expected %h", $time, got.aluOut, exp.aluOut);
            errors++;
        end
        if (got.zero !== exp.zero) begin
            $display("ERR %0t: zero %b, expected %b", $time, got.zero, exp.zero);
            errors++;
        end
        if (got.ofl !== exp.ofl) begin
            $display("ERR %0t: ofl %b, expected %b", $time, got.ofl, exp.ofl);
            errors++;
        end
        if (got.writeEn !== exp.writeEn) begin
            $display("ERR %0t: writeEn %b, expected %b", $time, got.writeEn, exp.writeEn);
            errors++;
        end
    endtask

    task automatic checkControl(input aluPkg::exResultT got, input aluPkg::exResultT exp);
        if (got.branchTaken !== exp.branchTaken) begin
            $display("ERR %0t: branchTaken %b, expected %b", $time, got.branchTaken,
                     exp.branchTaken);
            errors++;
        end
        if (got.branchTarget !== exp.branchTarget) begin
            $display("ERR %0t: branchTarget %h, expected %h", $time, got.branchTarget,
                     exp.branchTarget);
            errors++;
        end
    endtask

    // Result register clears and no strobe comes out before the first instruction
    task automatic checkReset();
        int errorsBefore;

        errorsBefore = errors;
        if (result !== '0) begin
            $display("ERR %0t: result %h after reset, expected all zero", $time, result);
            errors++;
        end
        if (resultValid !== 1'b0) begin
            $display("ERR %0t: resultValid high right after reset", $time);
            errors++;
        end
        checkIdle(3);
        testsRun++;
        if (errors == errorsBefore) begin
            $display("reset: ok");
        end else begin
            $display("reset: mismatch");
            failedTests++;
        end
    endtask

    task automatic runLine();
        aluPkg::exResultT expected;
        int               idle;
        int               latency;
        int               errorsBefore;
        bit               seen;

        errorsBefore = errors;
        // Zero idle cycles gives a back-to-back strobe
        idle = int'(nextRandom() % 32'd4);
        if (idle > 0) begin
            instrValid = 1'b0;
            checkIdle(idle);
        end
        driveInstr(traceFields[0], traceFields[1], traceFields[2], traceFields[3]);
        waitResult(seen, latency);
        testsRun++;
        if (!seen) begin
            $display("Timeout: no result within %0d cycles for instruction %h", TIMEOUT,
                     traceFields[0]);
            timedOut = 1'b1;
            failedTests++;
        end else begin
            if (latency != 1) begin
                $display("ERR %0t: result after %0d cycles, expected 1", $time, latency);
                errors++;
            end
            expected.aluOut       = traceFields[4];
            expected.zero         = traceFields[5][0];
            expected.ofl          = traceFields[6][0];
            expected.writeEn      = traceFields[7][0];
            expected.branchTaken  = traceFields[8][0];
            expected.branchTarget = traceFields[9];
            checkData(result, expected);
            checkControl(result, expected);
            if (errors == errorsBefore) begin
                $display("test %0d instr %h: ok", testsRun, traceFields[0]);
            end else begin
                $display("test %0d instr %h: mismatch", testsRun, traceFields[0]);
                failedTests++;
            end
        end
    endtask

    initial begin
        int    fd;
        int    code;
        int    fieldCount;
        int    lineNo;
        int    waitCycles;
        bit    done;
        string text;

        instrValid  = 1'b0;
        instr       = '0;
        rsData      = '0;
        rtData      = '0;
        pc          = '0;
        lcgState    = 32'd75166;
        errors      = 0;
        testsRun    = 0;
        failedTests = 0;
        timedOut    = 1'b0;
        done        = 1'b0;
        fd          = 0;
        text        = "";

        // Reset release, sampled on rising edges
        waitCycles = 0;
        while (rstN !== 1'b1 && waitCycles < TIMEOUT) begin
            @(posedge clk);
            waitCycles++;
        end
        if (rstN !== 1'b1) begin
            $display("Timeout: reset was never released");
            timedOut = 1'b1;
        end else begin
            @(negedge clk);
            checkReset();
            fd = $fopen(TRACE_FILE, "r");
            if (fd == 0) begin
                $display("Could not open the trace file %s", TRACE_FILE);
                errors++;
            end
        end
        done = timedOut || (fd == 0);

        // Comment and blank lines scan no fields
        lineNo = 0;
        while (!done && !timedOut && lineNo < MAX_LINES) begin
            code = $fgets(text, fd);
            lineNo++;
            if (code == 0) begin
                done = 1'b1;
            end else begin
                fieldCount = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h",
                                     traceFields[0], traceFields[1], traceFields[2],
                                     traceFields[3], traceFields[4], traceFields[5],
                                     traceFields[6], traceFields[7], traceFields[8],
                                     traceFields[9]);
                if (fieldCount == FIELDS) begin
                    runLine();
                end else if (fieldCount > 0) begin
                    $display("Trace line %0d has %0d fields instead of %0d", lineNo,
                             fieldCount, FIELDS);
                    errors++;
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        // Last result must not repeat
        instrValid = 1'b0;
        if (!timedOut) begin
            checkIdle(2);
        end
        if (testsRun < 2) begin
            $display("No instruction lines were read from the trace");
        end

        $display("Counts: %0d tests, %0d with mismatches, %0d errors", testsRun, failedTests,
                 errors);
        if (errors == 0 && failedTests == 0 && !timedOut && testsRun > 1) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+rtl
rtl/isaPkg.sv
rtl/aluPkg.sv
rtl/shifter.sv
rtl/claAdder.sv
rtl/aluBranchJump.sv
rtl/instrDecode.sv
rtl/branchResolve.sv
rtl/executeStage.sv
testbench/tbClock.sv
testbench/tbExecute.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tbExecute
FILELIST  = list.f
OBJDIR    = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation reported a failure"; exit 1; \
	elif ! grep -q "Test passed" $(LOG); then \
		echo "Simulation ended without a verdict"; exit 1; \
	fi

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- testbench/exec_trace.txt
// instr rsData rtData pc aluOut zero ofl writeEn branchTaken branchTarget, all in hex
// Register forms use rs, rt; immediates sit in the instruction word
4001 7FFF 0000 0100 8000 0 1 1 0 0102 // ADDI 7FFF + 1, signed overflow
4803 0005 0000 0102 FFFE 0 0 1 0 0104 // SUBI 3 - 5
D800 1234 4321 0104 5555 0 0 1 0 0106 // ADD
D800 8000 8000 0106 0000 1 1 1 0 0108 // ADD overflow to zero
D801 0001 8000 0108 7FFF 0 1 1 0 010A // SUB rt - rs overflows
D802 F0F0 FF00 010A 0FF0 0 0 1 0 010C // XOR
D803 F0F0 FF00 010C 00F0 0 0 1 0 010E // ANDN rs and not rt
501F 1234 0000 010E 122B 0 0 1 0 0110 // XORI zero-extended 1F
5810 FFFF 0000 0110 FFEF 0 0 1 0 0112 // ANDNI 10
F800 FFFF 0001 0112 0001 0 1 1 0 0114 // SCO carry out
F800 7FFF 0001 0114 0000 1 0 1 0 0116 // SCO no carry
A004 1234 0000 0116 2341 0 0 1 0 0118 // ROLI 4
A80F 0003 0000 0118 8000 0 0 1 0 011A // SLLI 15
B800 8001 0000 011A 8001 0 0 1 0 011C // SRLI 0
B004 1234 0000 011C 4123 0 0 1 0 011E // RORI 4
D000 8001 0001 011E 0003 0 0 1 0 0120 // ROL by rt 1
D001 FFFF 000F 0120 8000 0 0 1 0 0122 // SLL by rt 15
D002 8001 000F 0122 0003 0 0 1 0 0124 // ROR by rt 15
D003 8000 0004 0124 0800 0 0 1 0 0126 // SRL by rt 4
C800 1234 0000 0126 2C48 0 0 1 0 0128 // BTR
E000 1234 1234 0128 0001 0 0 1 0 012A // SEQ equal
E000 8000 0001 012A 0000 1 1 1 0 012C // SEQ difference overflows
E800 8000 0001 012C 0001 0 1 1 0 012E // SLT -32768 < 1
E800 7FFF FFFF 012E 0000 1 1 1 0 0130 // SLT 32767 < -1 is false
F000 FFFF FFFF 0130 0001 0 0 1 0 0132 // SLE equal
F000 8000 7FFF 0132 0001 0 1 1 0 0134 // SLE -32768 <= 32767
C080 0000 0000 0134 FF80 0 0 1 0 0136 // LBI 80 sign-extended
90AB 1234 0000 0136 34AB 0 0 1 0 0138 // SLBI AB
6010 0000 0000 0200 0000 1 0 0 1 0212 // BEQZ taken
6010 0001 0000 0200 0001 0 0 0 0 0202 // BEQZ not taken
68F0 0005 0000 0300 0005 0 0 0 1 02F2 // BNEZ taken, offset -16
68F0 0000 0000 0300 0000 1 0 0 0 0302 // BNEZ not taken
7004 8000 0000 0400 8000 0 0 0 1 0406 // BLTZ taken
7004 0000 0000 0400 0000 1 0 0 0 0402 // BLTZ not taken on zero
787F 0000 0000 0500 0000 1 0 0 1 0581 // BGEZ taken on zero
787F FFFF 0000 0500 FFFF 0 0 0 0 0502 // BGEZ not taken
2400 0000 0000 1000 0000 1 0 0 1 0C02 // J displacement -1024
2810 2000 0000 0600 2010 0 0 0 1 2010 // JR rs + 10
28FE 2000 0000 0600 1FFE 0 1 0 1 1FFE // JR rs - 2, carry out
